// ==== Makefile ====
.PHONY: sim clean

sim:
	rm -f sim.log
	verilator --binary --timing -Wno-fatal --top-module operator_control_tb -f list.f -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== channel_reg_file.sv ====
`include "opl3_config.svh"

module channel_reg_file (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           reg_wr_valid,
    input  logic                           reg_wr_bank,
    input  logic [`OPL_REG_ADDR_WIDTH-1:0] reg_wr_address,
    input  logic [`OPL_REG_DATA_WIDTH-1:0] reg_wr_data,
    input  logic                           slot_rd,
    input  logic                           slot_bank,
    input  logic [`OPL_CH_ADDR_WIDTH-1:0]  key_ch_addr,
    input  logic [`OPL_CH_ADDR_WIDTH-1:0]  fb_ch_addr,
    output logic [9:0]                     fnum,
    output logic [2:0]                     block,
    output logic                           kon,
    output logic [2:0]                     fb,
    output logic                           cnt
);
    import opl3_pkg::*;

    localparam int AW = `OPL_CH_ADDR_WIDTH;
    localparam logic [`OPL_REG_ADDR_WIDTH-1:0] CH_BASE [3] = '{
        `OPL_BASE_FNUM_LO, `OPL_BASE_KON_BLK, `OPL_BASE_FB_CNT
    };

    reg_byte_u ch_q [3];  // fnum low, kon/block/fnum high, fb/cnt

    for (genvar i = 0; i < 3; i++) begin : g_ch_mem
        logic [`OPL_REG_ADDR_WIDTH-1:0] wr_offset;
        logic [AW-1:0]                  rd_addr;

        assign wr_offset = reg_wr_address - CH_BASE[i];
        // feedback follows the physical channel, key and pitch the paired one
        assign rd_addr   = (i == 2) ? fb_ch_addr : key_ch_addr;

        reg_bank_mem #(.DEPTH(`OPL_CHANNELS_PER_BANK), .WIDTH(`OPL_REG_DATA_WIDTH)) mem_inst (
            .clk, .arst_n,
            .wr_en(reg_wr_valid && wr_offset < `OPL_CHANNELS_PER_BANK),
            .wr_bank(reg_wr_bank),
            .wr_addr(wr_offset[AW-1:0]),
            .wr_data(reg_wr_data),
            .rd_en(slot_rd),
            .rd_bank(slot_bank),
            .rd_addr(rd_addr),
            .rd_data(ch_q[i])
        );
    end

    assign fnum  = {ch_q[1].kon_blk.fnum_hi, ch_q[0]};
    assign block = ch_q[1].kon_blk.block;
    assign kon   = ch_q[1].kon_blk.kon;
    assign fb    = ch_q[2].fb_cnt.fb;
    assign cnt   = ch_q[2].fb_cnt.cnt;
endmodule

// ==== list.f ====
+incdir+.
opl3_pkg.sv
reg_bank_mem.sv
slot_sequencer.sv
slot_map.sv
operator_reg_file.sv
channel_reg_file.sv
operator_control.sv
tb_clock_gen.sv
operator_control_tb.sv

// ==== operator_control.sv ====
`include "opl3_config.svh"

module operator_control (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           sample_clk_en,
    input  logic                           reg_wr_valid,
    input  logic                           reg_wr_bank,
    input  logic [`OPL_REG_ADDR_WIDTH-1:0] reg_wr_address,
    input  logic [`OPL_REG_DATA_WIDTH-1:0] reg_wr_data,
    input  logic [`OPL_CONN_SEL_WIDTH-1:0] connection_sel,
    input  logic                           ryt,
    output logic                           slot_valid,
    output logic                           slot_bank,
    output logic [`OPL_OP_NUM_WIDTH-1:0]   slot_op_num,
    output logic                           am,
    output logic                           vib,
    output logic                           egt,
    output logic                           ksr,
    output logic [3:0]                     mult,
    output logic [1:0]                     ksl,
    output logic [5:0]                     tl,
    output logic [3:0]                     ar,
    output logic [3:0]                     dr,
    output logic [3:0]                     sl,
    output logic [3:0]                     rr,
    output logic [`OPL_WS_WIDTH-1:0]       ws,
    output logic [9:0]                     fnum,
    output logic [2:0]                     block,
    output logic                           kon,
    output logic [2:0]                     fb,
    output logic                           cnt,
    output logic                           use_feedback,
    output opl3_pkg::op_type_e             op_type,
    output logic                           ops_done_pulse
);
    logic                          slot_rd;
    logic [`OPL_OP_ADDR_WIDTH-1:0] op_rd_addr;
    logic [`OPL_CH_ADDR_WIDTH-1:0] key_ch_addr;
    logic [`OPL_CH_ADDR_WIDTH-1:0] fb_ch_addr;

    slot_sequencer slot_sequencer_inst (
        .clk, .arst_n, .sample_clk_en,
        .slot_rd, .slot_bank, .slot_op_num, .slot_valid, .ops_done_pulse
    );

    slot_map slot_map_inst (
        .clk, .arst_n, .slot_rd, .slot_bank, .slot_op_num, .connection_sel, .ryt,
        .op_rd_addr, .key_ch_addr, .fb_ch_addr, .use_feedback, .op_type
    );

    operator_reg_file operator_reg_file_inst (
        .clk, .arst_n, .reg_wr_valid, .reg_wr_bank, .reg_wr_address, .reg_wr_data,
        .slot_rd, .slot_bank, .op_rd_addr,
        .am, .vib, .egt, .ksr, .mult, .ksl, .tl, .ar, .dr, .sl, .rr, .ws
    );

    channel_reg_file channel_reg_file_inst (
        .clk, .arst_n, .reg_wr_valid, .reg_wr_bank, .reg_wr_address, .reg_wr_data,
        .slot_rd, .slot_bank, .key_ch_addr, .fb_ch_addr,
        .fnum, .block, .kon, .fb, .cnt
    );
endmodule

// ==== operator_control_tb.sv ====
`include "opl3_config.svh"

module operator_control_tb;
    import opl3_pkg::*;

    localparam int NUM_ROUNDS       = 6;
    localparam int WRITES_PER_ROUND = 60;
    localparam int NUM_SWEEPS       = 1 + 2 * NUM_ROUNDS;   // reset sweep plus a chained pair per round
    localparam int NUM_WRITES       = NUM_ROUNDS * (WRITES_PER_ROUND + 1);
    localparam int TIMEOUT_CYCLES   = NUM_SWEEPS * 80 + NUM_WRITES + 200;
    localparam int SWEEP_CYCLES     = 73;                   // strobe to done pulse

    localparam logic [7:0] OP_BASES [5] = '{
        `OPL_BASE_AVEKM, `OPL_BASE_KSL_TL, `OPL_BASE_AR_DR, `OPL_BASE_SL_RR, `OPL_BASE_WS
    };
    localparam logic [7:0] CH_BASES [3] = '{
        `OPL_BASE_FNUM_LO, `OPL_BASE_KON_BLK, `OPL_BASE_FB_CNT
    };
    localparam logic [7:0] ALL_BASES [8] = '{
        `OPL_BASE_AVEKM, `OPL_BASE_KSL_TL, `OPL_BASE_AR_DR, `OPL_BASE_SL_RR,
        `OPL_BASE_FNUM_LO, `OPL_BASE_KON_BLK, `OPL_BASE_FB_CNT, `OPL_BASE_WS
    };

    logic                           clk;
    logic                           arst_n;
    logic                           sample_clk_en;
    logic                           reg_wr_valid;
    logic                           reg_wr_bank;
    logic [`OPL_REG_ADDR_WIDTH-1:0] reg_wr_address;
    logic [`OPL_REG_DATA_WIDTH-1:0] reg_wr_data;
    logic [`OPL_CONN_SEL_WIDTH-1:0] connection_sel;
    logic                           ryt;
    logic                           slot_valid;
    logic                           slot_bank;
    logic [`OPL_OP_NUM_WIDTH-1:0]   slot_op_num;
    logic                           am;
    logic                           vib;
    logic                           egt;
    logic                           ksr;
    logic [3:0]                     mult;
    logic [1:0]                     ksl;
    logic [5:0]                     tl;
    logic [3:0]                     ar;
    logic [3:0]                     dr;
    logic [3:0]                     sl;
    logic [3:0]                     rr;
    logic [`OPL_WS_WIDTH-1:0]       ws;
    logic [9:0]                     fnum;
    logic [2:0]                     block;
    logic                           kon;
    logic [2:0]                     fb;
    logic                           cnt;
    logic                           use_feedback;
    op_type_e                       op_type;
    logic                           ops_done_pulse;

    reg_byte_u op_model [2][5][`OPL_OP_MEM_DEPTH];      // bank, range, offset
    reg_byte_u ch_model [2][3][`OPL_CHANNELS_PER_BANK];
    int        err_cnt   = 0;
    int        check_cnt = 0;
    int        cycle_cnt = 0;

    tb_clock_gen #(.PERIOD(8)) clk_gen_inst (.clk(clk));

    operator_control operator_control_inst (
        .clk, .arst_n, .sample_clk_en,
        .reg_wr_valid, .reg_wr_bank, .reg_wr_address, .reg_wr_data,
        .connection_sel, .ryt,
        .slot_valid, .slot_bank, .slot_op_num,
        .am, .vib, .egt, .ksr, .mult, .ksl, .tl, .ar, .dr, .sl, .rr, .ws,
        .fnum, .block, .kon, .fb, .cnt,
        .use_feedback, .op_type, .ops_done_pulse
    );

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: no end of test after %0d cycles", cycle_cnt);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("[FAIL] t=%0t %s expected %0b actual %0b", $time, name, exp, act);
        end
    endtask

    task automatic check_field(input string name, input logic [9:0] exp, input logic [9:0] act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("[FAIL] t=%0t %s expected 0x%0h actual 0x%0h", $time, name, exp, act);
        end
    endtask

    task automatic check_type(input string name, input op_type_e exp, input op_type_e act);
        check_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("[FAIL] t=%0t %s expected %s actual %s", $time, name, exp.name(), act.name());
        end
    endtask

    function automatic logic exp_feedback(input logic bank, input int s, input logic pair,
                                          input logic rhy);
        if (s <= 2 || s == 12) begin
            return 1'b1;
        end
        if (s >= 6 && s <= 8) begin
            return !pair; // paired second half has no feedback
        end
        if (s == 13 || s == 14) begin
            return !(rhy && !bank);
        end
        return 1'b0;
    endfunction

    function automatic op_type_e exp_type(input logic bank, input int s, input logic rhy);
        if (bank || !rhy) begin
            return OP_NORMAL;
        end
        case (s)
            12, 15:  return OP_BASS_DRUM;
            13:      return OP_HI_HAT;
            14:      return OP_TOM_TOM;
            16:      return OP_SNARE_DRUM;
            17:      return OP_TOP_CYMBAL;
            default: return OP_NORMAL;
        endcase
    endfunction

    task automatic check_slot(input int k);
        logic      bank;
        int        s;
        int        oa;
        int        pc;
        int        kc;
        logic      pair;
        reg_byte_u op_b [5];
        reg_byte_u ch_b [3];
        bank = 1'(k / 18);
        s    = k % 18;
        oa   = s + 2 * (s / 6);    // skips the two unused offsets after each group
        pc   = 3 * (s / 6) + s % 3;
        pair = connection_sel[s % 3 + 3 * int'(bank)];
        kc   = (s >= 6 && s <= 11 && pair) ? pc - 3 : pc;
        for (int i = 0; i < 5; i++) begin
            op_b[i] = op_model[bank][i][oa];
        end
        ch_b[0] = ch_model[bank][0][kc];
        ch_b[1] = ch_model[bank][1][kc];
        ch_b[2] = ch_model[bank][2][pc];
        check_bit("slot_bank", bank, slot_bank);
        check_field("slot_op_num", 10'(s), 10'(slot_op_num));
        check_bit("am", op_b[0].avekm.am, am);
        check_bit("vib", op_b[0].avekm.vib, vib);
        check_bit("egt", op_b[0].avekm.egt, egt);
        check_bit("ksr", op_b[0].avekm.ksr, ksr);
        check_field("mult", 10'(op_b[0].avekm.mult), 10'(mult));
        check_field("ksl", 10'(op_b[1].ksl_tl.ksl), 10'(ksl));
        check_field("tl", 10'(op_b[1].ksl_tl.tl), 10'(tl));
        check_field("ar", 10'(op_b[2].rates.hi), 10'(ar));
        check_field("dr", 10'(op_b[2].rates.lo), 10'(dr));
        check_field("sl", 10'(op_b[3].rates.hi), 10'(sl));
        check_field("rr", 10'(op_b[3].rates.lo), 10'(rr));
        check_field("ws", 10'(op_b[4][2:0]), 10'(ws));
        check_field("fnum", {ch_b[1].kon_blk.fnum_hi, ch_b[0]}, fnum);
        check_field("block", 10'(ch_b[1].kon_blk.block), 10'(block));
        check_bit("kon", ch_b[1].kon_blk.kon, kon);
        check_field("fb", 10'(ch_b[2].fb_cnt.fb), 10'(fb));
        check_bit("cnt", ch_b[2].fb_cnt.cnt, cnt);
        check_bit("use_feedback", exp_feedback(bank, s, pair, ryt), use_feedback);
        check_type("op_type", exp_type(bank, s, ryt), op_type);
    endtask

    task automatic write_reg(input logic bank, input logic [7:0] addr, input logic [7:0] data);
        logic [7:0] off;
        @(negedge clk);
        check_bit("slot_valid", 1'b0, slot_valid); // sequencer must be idle here
        check_bit("ops_done_pulse", 1'b0, ops_done_pulse);
        reg_wr_valid   = 1'b1;
        reg_wr_bank    = bank;
        reg_wr_address = addr;
        reg_wr_data    = data;
        for (int i = 0; i < 5; i++) begin
            off = addr - OP_BASES[i];
            if (off < `OPL_OP_MEM_DEPTH) begin
                op_model[bank][i][off] = data;
            end
        end
        for (int i = 0; i < 3; i++) begin
            off = addr - CH_BASES[i];
            if (off < `OPL_CHANNELS_PER_BANK) begin
                ch_model[bank][i][off] = data;
            end
        end
    endtask

    task automatic do_writes(input int count);
        logic       bank;
        logic [7:0] addr;
        for (int i = 0; i < count; i++) begin
            bank = 1'($urandom % 2);
            if ($urandom % 8 == 0) begin
                addr = 8'($urandom);
            end else begin
                addr = ALL_BASES[$urandom % 8] + 8'($urandom % 32); // includes unused offsets
            end
            write_reg(bank, addr, 8'($urandom));
        end
        @(negedge clk);
        reg_wr_valid = 1'b0;
    endtask

    // started means the strobe was already taken at the end of the previous sweep
    task automatic run_sweep(input bit started, input bit chain);
        if (!started) begin
            @(negedge clk);
            sample_clk_en = 1'b1;
        end
        for (int n = 1; n <= SWEEP_CYCLES; n++) begin
            @(negedge clk);
            if (n % 2 == 0 && n < SWEEP_CYCLES) begin
                check_bit("slot_valid", 1'b1, slot_valid);
                check_slot((n - 2) / 2);
            end else begin
                check_bit("slot_valid", 1'b0, slot_valid);
            end
            check_bit("ops_done_pulse", n == SWEEP_CYCLES, ops_done_pulse);
            if (n < SWEEP_CYCLES) begin
                sample_clk_en = ($urandom % 8) == 0; // stray strobes are ignored mid-sweep
            end else begin
                sample_clk_en = chain;
            end
        end
    endtask

    initial begin
        void'($urandom(32'h7e08));
        arst_n         = 1'b0;
        sample_clk_en  = 1'b0;
        reg_wr_valid   = 1'b0;
        reg_wr_bank    = 1'b0;
        reg_wr_address = '0;
        reg_wr_data    = '0;
        connection_sel = '0;
        ryt            = 1'b0;
        for (int b = 0; b < 2; b++) begin
            for (int i = 0; i < 5; i++) begin
                for (int a = 0; a < `OPL_OP_MEM_DEPTH; a++) begin
                    op_model[b][i][a] = '0;
                end
            end
            for (int i = 0; i < 3; i++) begin
                for (int a = 0; a < `OPL_CHANNELS_PER_BANK; a++) begin
                    ch_model[b][i][a] = '0;
                end
            end
        end
        repeat (8) @(negedge clk);
        check_bit("slot_valid", 1'b0, slot_valid); // reset values
        check_bit("ops_done_pulse", 1'b0, ops_done_pulse);
        check_bit("use_feedback", 1'b0, use_feedback);
        check_type("op_type", OP_NORMAL, op_type);
        arst_n = 1'b1;

        run_sweep(1'b0, 1'b0); // cleared memories

        for (int r = 0; r < NUM_ROUNDS; r++) begin
            do_writes(WRITES_PER_ROUND);
            connection_sel = `OPL_CONN_SEL_WIDTH'($urandom);
            ryt            = 1'(r % 2);
            run_sweep(1'b0, 1'b1);
            run_sweep(1'b1, 1'b0); // back-to-back start at the done pulse
        end

        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end
endmodule

// ==== operator_reg_file.sv ====
`include "opl3_config.svh"

module operator_reg_file (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           reg_wr_valid,
    input  logic                           reg_wr_bank,
    input  logic [`OPL_REG_ADDR_WIDTH-1:0] reg_wr_address,
    input  logic [`OPL_REG_DATA_WIDTH-1:0] reg_wr_data,
    input  logic                           slot_rd,
    input  logic                           slot_bank,
    input  logic [`OPL_OP_ADDR_WIDTH-1:0]  op_rd_addr,
    output logic                           am,
    output logic                           vib,
    output logic                           egt,
    output logic                           ksr,
    output logic [3:0]                     mult,
    output logic [1:0]                     ksl,
    output logic [5:0]                     tl,
    output logic [3:0]                     ar,
    output logic [3:0]                     dr,
    output logic [3:0]                     sl,
    output logic [3:0]                     rr,
    output logic [`OPL_WS_WIDTH-1:0]       ws
);
    import opl3_pkg::*;

    localparam int AW = `OPL_OP_ADDR_WIDTH;
    localparam logic [`OPL_REG_ADDR_WIDTH-1:0] BYTE_BASE [4] = '{
        `OPL_BASE_AVEKM, `OPL_BASE_KSL_TL, `OPL_BASE_AR_DR, `OPL_BASE_SL_RR
    };

    reg_byte_u                      byte_q [4];
    logic [`OPL_REG_ADDR_WIDTH-1:0] ws_offset;

    for (genvar i = 0; i < 4; i++) begin : g_byte_mem
        logic [`OPL_REG_ADDR_WIDTH-1:0] wr_offset;

        assign wr_offset = reg_wr_address - BYTE_BASE[i]; // wraps high below the base

        reg_bank_mem #(.DEPTH(`OPL_OP_MEM_DEPTH), .WIDTH(`OPL_REG_DATA_WIDTH)) mem_inst (
            .clk, .arst_n,
            .wr_en(reg_wr_valid && wr_offset < `OPL_OP_MEM_DEPTH),
            .wr_bank(reg_wr_bank),
            .wr_addr(wr_offset[AW-1:0]),
            .wr_data(reg_wr_data),
            .rd_en(slot_rd),
            .rd_bank(slot_bank),
            .rd_addr(op_rd_addr),
            .rd_data(byte_q[i])
        );
    end

    assign ws_offset = reg_wr_address - `OPL_BASE_WS;

    reg_bank_mem #(.DEPTH(`OPL_OP_MEM_DEPTH), .WIDTH(`OPL_WS_WIDTH)) ws_mem (
        .clk, .arst_n,
        .wr_en(reg_wr_valid && ws_offset < `OPL_OP_MEM_DEPTH),
        .wr_bank(reg_wr_bank),
        .wr_addr(ws_offset[AW-1:0]),
        .wr_data(reg_wr_data[`OPL_WS_WIDTH-1:0]), // upper bits unused
        .rd_en(slot_rd),
        .rd_bank(slot_bank),
        .rd_addr(op_rd_addr),
        .rd_data(ws)
    );

    assign am   = byte_q[0].avekm.am;
    assign vib  = byte_q[0].avekm.vib;
    assign egt  = byte_q[0].avekm.egt;
    assign ksr  = byte_q[0].avekm.ksr;
    assign mult = byte_q[0].avekm.mult;
    assign ksl  = byte_q[1].ksl_tl.ksl;
    assign tl   = byte_q[1].ksl_tl.tl;
    assign ar   = byte_q[2].rates.hi;
    assign dr   = byte_q[2].rates.lo;
    assign sl   = byte_q[3].rates.hi;
    assign rr   = byte_q[3].rates.lo;
endmodule

// ==== opl3_config.svh ====
`ifndef OPL3_CONFIG_SVH
`define OPL3_CONFIG_SVH

// bank and slot layout
`define OPL_NUM_BANKS          2
`define OPL_OPS_PER_BANK       18
`define OPL_CHANNELS_PER_BANK  9
`define OPL_OP_MEM_DEPTH       22  // operator offsets 0x00 to 0x15
`define OPL_SLOT_CYCLES        2   // clocks spent on each slot

// widths
`define OPL_OP_NUM_WIDTH       5
`define OPL_OP_ADDR_WIDTH      5
`define OPL_CH_ADDR_WIDTH      4
`define OPL_REG_ADDR_WIDTH     8
`define OPL_REG_DATA_WIDTH     8
`define OPL_WS_WIDTH           3
`define OPL_CONN_SEL_WIDTH     6   // one pairing bit per 4-op channel pair, 3 per bank

// register range bases
`define OPL_BASE_AVEKM         8'h20
`define OPL_BASE_KSL_TL        8'h40
`define OPL_BASE_AR_DR         8'h60
`define OPL_BASE_SL_RR         8'h80
`define OPL_BASE_FNUM_LO       8'hA0
`define OPL_BASE_KON_BLK       8'hB0
`define OPL_BASE_FB_CNT        8'hC0
`define OPL_BASE_WS            8'hE0

`endif

// ==== opl3_pkg.sv ====
package opl3_pkg;

    // one stored register byte, read back through the layout of its range
    typedef union packed {
        struct packed {
            logic       am;       // tremolo enable
            logic       vib;      // vibrato enable
            logic       egt;      // sustain hold
            logic       ksr;      // key scale rate
            logic [3:0] mult;     // frequency multiplier
        } avekm;
        struct packed {
            logic [1:0] ksl;      // key scale level
            logic [5:0] tl;       // total level
        } ksl_tl;
        struct packed {
            logic [3:0] hi;       // ar or sl
            logic [3:0] lo;       // dr or rr
        } rates;
        struct packed {
            logic [1:0] spare;
            logic       kon;
            logic [2:0] block;    // octave
            logic [1:0] fnum_hi;
        } kon_blk;
        struct packed {
            logic [3:0] spare;
            logic [2:0] fb;       // feedback depth
            logic       cnt;      // connection
        } fb_cnt;
    } reg_byte_u;

    // operator role, rhythm mode only applies in bank 0
    typedef enum logic [2:0] {
        OP_NORMAL,
        OP_BASS_DRUM,
        OP_HI_HAT,
        OP_TOM_TOM,
        OP_SNARE_DRUM,
        OP_TOP_CYMBAL
    } op_type_e;

endpackage

// ==== reg_bank_mem.sv ====
`include "opl3_config.svh"

module reg_bank_mem #(
    parameter int DEPTH = `OPL_OP_MEM_DEPTH,
    parameter int WIDTH = `OPL_REG_DATA_WIDTH
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     wr_en,
    input  logic                     wr_bank,
    input  logic [$clog2(DEPTH)-1:0] wr_addr,
    input  logic [WIDTH-1:0]         wr_data,
    input  logic                     rd_en,
    input  logic                     rd_bank,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output logic [WIDTH-1:0]         rd_data
);
    logic [WIDTH-1:0] mem [`OPL_NUM_BANKS][DEPTH];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < `OPL_NUM_BANKS; b++) begin
                for (int i = 0; i < DEPTH; i++) begin
                    mem[b][i] <= '0;
                end
            end
        end else if (wr_en) begin
            mem[wr_bank][wr_addr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_data <= '0;
        end else if (rd_en) begin
            rd_data <= mem[rd_bank][rd_addr]; // held until the next slot read
        end
    end
endmodule

// ==== slot_map.sv ====
`include "opl3_config.svh"

module slot_map (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           slot_rd,
    input  logic                           slot_bank,
    input  logic [`OPL_OP_NUM_WIDTH-1:0]   slot_op_num,
    input  logic [`OPL_CONN_SEL_WIDTH-1:0] connection_sel,
    input  logic                           ryt,
    output logic [`OPL_OP_ADDR_WIDTH-1:0]  op_rd_addr,
    output logic [`OPL_CH_ADDR_WIDTH-1:0]  key_ch_addr,
    output logic [`OPL_CH_ADDR_WIDTH-1:0]  fb_ch_addr,
    output logic                           use_feedback,
    output opl3_pkg::op_type_e             op_type
);
    import opl3_pkg::*;

    logic [1:0] grp;        // slots 0-5, 6-11, 12-17
    logic [1:0] slot_mod3;
    logic [2:0] sel_idx;
    logic       pair_bit;
    logic       rhythm;
    logic       fb_next;
    op_type_e   type_next;

    assign grp       = (slot_op_num < 6) ? 2'd0 : (slot_op_num < 12) ? 2'd1 : 2'd2;
    assign slot_mod3 = 2'(slot_op_num % 3);
    assign sel_idx   = {1'b0, slot_mod3} + (slot_bank ? 3'd3 : 3'd0);
    assign pair_bit  = connection_sel[sel_idx];
    assign rhythm    = !slot_bank && ryt;

    // operator offsets skip 0x06-0x07 and 0x0E-0x0F
    assign op_rd_addr = slot_op_num + {grp, 1'b0};
    assign fb_ch_addr = {2'b00, grp} * 4'd3 + {2'b00, slot_mod3};

    // second half of a 4-op pair takes key and fnum from its partner
    assign key_ch_addr = (grp == 2'd1 && pair_bit) ? fb_ch_addr - 4'd3 : fb_ch_addr;

    always_comb begin
        case (slot_op_num)
            0, 1, 2, 12: fb_next = 1'b1;
            6, 7, 8:     fb_next = !pair_bit;
            13, 14:      fb_next = !rhythm;  // hi-hat and tom-tom in rhythm mode
            default:     fb_next = 1'b0;
        endcase
    end

    always_comb begin
        type_next = OP_NORMAL;
        if (rhythm) begin
            case (slot_op_num)
                12, 15:  type_next = OP_BASS_DRUM;
                13:      type_next = OP_HI_HAT;
                14:      type_next = OP_TOM_TOM;
                16:      type_next = OP_SNARE_DRUM;
                17:      type_next = OP_TOP_CYMBAL;
                default: type_next = OP_NORMAL;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            use_feedback <= 1'b0;
            op_type      <= OP_NORMAL;
        end else if (slot_rd) begin
            use_feedback <= fb_next;   // same cycle as the register file data
            op_type      <= type_next;
        end
    end
endmodule

// ==== slot_sequencer.sv ====
`include "opl3_config.svh"

module slot_sequencer (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         sample_clk_en,
    output logic                         slot_rd,
    output logic                         slot_bank,
    output logic [`OPL_OP_NUM_WIDTH-1:0] slot_op_num,
    output logic                         slot_valid,
    output logic                         ops_done_pulse
);
    localparam int NUM_SLOTS   = `OPL_NUM_BANKS * `OPL_OPS_PER_BANK;
    localparam int STATE_WIDTH = $clog2(NUM_SLOTS + 1);
    localparam int CYC_WIDTH   = $clog2(`OPL_SLOT_CYCLES);
    localparam int NUM_WIDTH   = `OPL_OP_NUM_WIDTH;

    logic [STATE_WIDTH-1:0] state;   // 0 is idle, 1..36 are slots
    logic [CYC_WIDTH-1:0]   cyc_cnt;
    logic                   last_cyc;

    assign last_cyc = cyc_cnt == CYC_WIDTH'(`OPL_SLOT_CYCLES - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= '0;
            cyc_cnt <= '0;
        end else if (state == '0) begin
            cyc_cnt <= '0;
            if (sample_clk_en) begin
                state <= STATE_WIDTH'(1); // strobes mid-sweep are dropped
            end
        end else if (last_cyc) begin
            cyc_cnt <= '0;
            state   <= (state == STATE_WIDTH'(NUM_SLOTS)) ? '0 : state + 1'b1;
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

    // bank and number are stable for both cycles of a slot
    assign slot_rd   = (state != '0) && (cyc_cnt == '0);
    assign slot_bank = state > STATE_WIDTH'(`OPL_OPS_PER_BANK);

    always_comb begin
        if (state == '0) begin
            slot_op_num = '0;
        end else if (slot_bank) begin
            slot_op_num = NUM_WIDTH'(state - STATE_WIDTH'(`OPL_OPS_PER_BANK + 1));
        end else begin
            slot_op_num = NUM_WIDTH'(state - STATE_WIDTH'(1));
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_valid     <= 1'b0;
            ops_done_pulse <= 1'b0;
        end else begin
            slot_valid     <= slot_rd; // lines up with memory read data
            ops_done_pulse <= slot_valid && slot_bank
                              && (slot_op_num == NUM_WIDTH'(`OPL_OPS_PER_BANK - 1));
        end
    end
endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
    end

    always #(PERIOD / 2) clk = ~clk; // free running, 50% duty
endmodule
